/* dv/io_irq_vectors.txt */
# cmd addr data expect, hex; W/R bus write/read, P int0 level, M csr_meie
# U rx byte (expect = stop bit), C wait cycles, G irq (data = pulses), T group
T 0001 00000000 00000000
R 3E80 00000000 00000000
R 3E81 00000000 00000000
R 3E90 00000000 00000000
R 3EA0 00000000 00000000
R 3EA1 00000000 00000000
R 3EA2 00000000 00000000
R 0100 00000000 00000000
G 0000 00000000 00000000
T 0002 00000000 00000000
W 3E80 FFFFFFFF 00000000
R 3E80 00000000 00000007
W 3EA0 A5A50000 00000000
R 3EA0 00000000 A5A50000
W 3EA1 12345678 00000000
R 3EA1 00000000 12345678
W 3EA2 9ABCDEF0 00000000
R 3EA2 00000000 9ABCDEF0
T 0003 00000000 00000000
W 3E80 00000002 00000000
P 0000 00000001 00000000
C 0000 00000004 00000000
R 3E81 00000000 00000000
P 0000 00000000 00000000
C 0000 00000004 00000000
M 0000 00000001 00000000
W 3E80 00000005 00000000
P 0000 00000001 00000000
C 0000 00000004 00000000
R 3E81 00000000 00000000
P 0000 00000000 00000000
C 0000 00000004 00000000
G 0000 00000000 00000000
W 3E80 00000007 00000000
P 0000 00000001 00000000
C 0000 00000004 00000000
R 3E81 00000000 00000002
G 0000 00000001 00000001
P 0000 00000000 00000000
T 0004 00000000 00000000
U 0000 0000005A 00000001
R 3E81 00000000 00000003
G 0000 00000000 00000001
W 3E81 00000005 00000000
R 3E81 00000000 00000001
R 3E90 00000000 0000015A
R 3E90 00000000 0000005A
U 0000 000000C3 00000000
R 3E81 00000000 00000001
R 3E90 00000000 0000025A
R 3E90 00000000 0000005A
W 3E81 00000000 00000000
R 3E81 00000000 00000000
G 0000 00000000 00000000
T 0005 00000000 00000000
W 3EA2 00000040 00000000
W 3EA1 00000030 00000000
W 3EA0 00000001 00000000
C 0000 00000020 00000000
R 3E81 00000000 00000004
G 0000 00000001 00000001
W 3EA0 00000000 00000000
W 3E81 00000000 00000000
R 3E81 00000000 00000000
W 3EA1 00000030 00000000
C 0000 00000020 00000000
R 3E81 00000000 00000000
R 3EA1 00000000 00000030
G 0000 00000000 00000000

/* compile.f */
+incdir+logic
logic/io_irq_pkg.sv
logic/uart_rx_fsm.sv
logic/io_timer.sv
logic/interrupter.sv
logic/io_irq_top.sv
dv/tb_io_irq.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the I/O interrupt testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	-f compile.f --top-module tb_io_irq \
	--Mdir obj_dir -o tb_io_irq
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/tb_io_irq)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST PASSED" <<< "$sim_out"; then
	exit 0
fi

echo "simulation did not report a pass"
exit 1

/* dv/tb_io_irq.sv */
/*
 * testbench for the I/O interrupt subsystem
 * replays bus, pin and UART vectors and checks read data and interrupts
 */
`default_nettype none
`include "io_irq_cfg.svh"

module tb_io_irq;
	timeunit 1ns;
	timeprecision 100ps;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                int0;
	logic                rx;
	logic                csr_meie;
	logic                io_we;
	io_irq_pkg::io_adr_t io_wadr;
	logic [31:0]         io_wdata;
	logic                io_radr_en;
	io_irq_pkg::io_adr_t io_radr;
	logic [31:0]         io_rdata_in;
	logic [31:0]         io_rdata;
	logic                g_interrupt;
	logic                g_interrupt_1shot;

	// one entry per vector line
	logic [7:0]  cmd_q[$];
	logic [31:0] adr_q[$];
	logic [31:0] dat_q[$];
	logic [31:0] exp_q[$];

	int cyc_cnt = 0;
	int timeout_limit = 1_000_000_000;
	int pulse_cnt = 0;
	int pulse_mark = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int grp_num = 0;
	int grp_checks = 0;
	int grp_errs = 0;
	int grp_total = 0;

	always #4 clk = ~clk;

	io_irq_top dut0 (
		.clk               (clk),
		.rst_n             (rst_n),
		.int0              (int0),
		.rx                (rx),
		.csr_meie          (csr_meie),
		.io_we             (io_we),
		.io_wadr           (io_wadr),
		.io_wdata          (io_wdata),
		.io_radr_en        (io_radr_en),
		.io_radr           (io_radr),
		.io_rdata_in       (io_rdata_in),
		.io_rdata          (io_rdata),
		.g_interrupt       (g_interrupt),
		.g_interrupt_1shot (g_interrupt_1shot)
	);

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// pulse is one full cycle, so it spans exactly one falling edge
	always @(negedge clk) begin
		if (g_interrupt_1shot)
			pulse_cnt <= pulse_cnt + 1;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] expv);
		check_cnt++;
		grp_checks++;
		if (got !== expv) begin
			err_cnt++;
			grp_errs++;
			$display("ERROR: %s = %h, expected %h", name, got, expv);
		end
	endtask

	// register map of the subsystem
	function automatic bit is_mapped(input logic [13:0] adr);
		return adr == `SYS_INT_ENABLE || adr == `SYS_INT_STATUS ||
		       adr == `UART_RXDATA || adr == `TMR_CTRL ||
		       adr == `TMR_COUNT || adr == `TMR_CMP;
	endfunction

	task automatic bus_write(input logic [13:0] adr, input logic [31:0] data);
		io_we    = 1'b1;
		io_wadr  = adr;
		io_wdata = data;
		next_cycle();
		io_we    = 1'b0;
	endtask

	// unmapped reads must pass the chain input through
	task automatic bus_read(input logic [13:0] adr, input logic [31:0] expv);
		logic [31:0] marker;
		logic [31:0] want;
		marker      = $urandom();
		want        = is_mapped(adr) ? expv : marker;
		io_radr_en  = 1'b1;
		io_radr     = adr;
		io_rdata_in = marker;
		next_cycle();
		io_radr_en  = 1'b0;
		@(negedge clk);
		check_val($sformatf("io_rdata @%h", adr), io_rdata, want);
		next_cycle();
	endtask

	// start, 8 data bits LSB first, stop, then 2 idle bits
	task automatic send_byte(input logic [7:0] data, input logic stop_bit);
		rx = 1'b0;
		repeat (`UART_CLKS_PER_BIT) next_cycle();
		for (int i = 0; i < 8; i++) begin
			rx = data[i];
			repeat (`UART_CLKS_PER_BIT) next_cycle();
		end
		rx = stop_bit;
		repeat (`UART_CLKS_PER_BIT) next_cycle();
		rx = 1'b1;
		repeat (2 * `UART_CLKS_PER_BIT) next_cycle();
	endtask

	task automatic check_irq(input int pulses, input logic level);
		@(negedge clk);
		#1;
		check_val("g_interrupt", {31'd0, g_interrupt}, {31'd0, level});
		check_val("g_interrupt_1shot count", pulse_cnt - pulse_mark, pulses);
		pulse_mark = pulse_cnt;
		next_cycle();
	endtask

	task automatic end_group();
		if (grp_num != 0) begin
			$display("group %0d done: %0d checks, %0d errors",
				grp_num, grp_checks, grp_errs);
			grp_total++;
		end
		grp_checks = 0;
		grp_errs   = 0;
	endtask

	task automatic load_vectors(output bit ok);
		int               fd;
		int               code;
		logic [7:0]       cmd;
		logic [31:0]      adr;
		logic [31:0]      dat;
		logic [31:0]      expv;
		logic [8*128-1:0] rest;
		ok = 1'b0;
		fd = $fopen("dv/io_irq_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open vector file dv/io_irq_vectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1)
				break;
			if (cmd == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h", adr, dat, expv);
				if (code != 3) begin
					$display("malformed vector line after %0d entries", cmd_q.size());
					$fclose(fd);
					return;
				end
				cmd_q.push_back(cmd);
				adr_q.push_back(adr);
				dat_q.push_back(dat);
				exp_q.push_back(expv);
			end
		end
		$fclose(fd);
		ok = 1'b1;
	endtask

	task automatic run_vector(input int idx);
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] expv;
		adr  = adr_q[idx];
		dat  = dat_q[idx];
		expv = exp_q[idx];
		case (cmd_q[idx])
			"T": begin
				end_group();
				grp_num = int'(adr);
			end
			"W": bus_write(adr[13:0], dat);
			"R": bus_read(adr[13:0], expv);
			"P": begin
				int0 = dat[0];
				next_cycle();
			end
			"M": begin
				csr_meie = dat[0];
				next_cycle();
			end
			"C": repeat (dat) next_cycle();
			"U": send_byte(dat[7:0], expv[0]);
			"G": check_irq(int'(dat), expv[0]);
			default: begin
				$display("unknown command %c in vector %0d", cmd_q[idx], idx);
				err_cnt++;
			end
		endcase
	endtask

	initial begin
		bit loaded;
		int budget;
		rst_n       = 1'b0;
		int0        = 1'b0;
		rx          = 1'b1;
		csr_meie    = 1'b0;
		io_we       = 1'b0;
		io_wadr     = '0;
		io_wdata    = 32'd0;
		io_radr_en  = 1'b0;
		io_radr     = '0;
		io_rdata_in = 32'd0;
		void'($urandom(32'h9606));
		load_vectors(loaded);
		if (loaded) begin
			// reset and settle, then the vector lines
			budget = 8;
			foreach (cmd_q[i]) begin
				if (cmd_q[i] == "C")
					budget += int'(dat_q[i]);
				else if (cmd_q[i] == "U")
					budget += 12 * `UART_CLKS_PER_BIT;
				else
					budget += 4;
			end
			timeout_limit = 2 * budget;
			repeat (2) @(posedge clk);
			#1;
			rst_n = 1'b1;
			next_cycle();
			foreach (cmd_q[i])
				run_vector(i);
		end else begin
			err_cnt++;
		end
		end_group();
		$display("%0d groups, %0d checks, %0d errors", grp_total, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/io_irq_top.sv */
/*
 * I/O interrupt subsystem top
 * UART receiver, timer and interrupter on one read chain
 */
`default_nettype none

module io_irq_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                int0,
	input  wire logic                rx,
	input  wire logic                csr_meie,
	input  wire logic                io_we,
	input  wire io_irq_pkg::io_adr_t io_wadr,
	input  wire logic [31:0]         io_wdata,
	input  wire logic                io_radr_en,
	input  wire io_irq_pkg::io_adr_t io_radr,
	input  wire logic [31:0]         io_rdata_in,
	output logic [31:0]              io_rdata,
	output logic                     g_interrupt,
	output logic                     g_interrupt_1shot
);

	logic [31:0] uart_rdata;
	logic [31:0] tmr_rdata;
	logic        rx_1shot;
	logic        tmr_1shot;

	// chain order: uart, timer, interrupter
	uart_rx_fsm u_uart_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx         (rx),
		.io_radr_en (io_radr_en),
		.io_radr    (io_radr),
		.rdata_in   (io_rdata_in),
		.rdata      (uart_rdata),
		.rx_1shot   (rx_1shot)
	);

	io_timer u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr_en (io_radr_en),
		.io_radr    (io_radr),
		.rdata_in   (uart_rdata),
		.rdata      (tmr_rdata),
		.tmr_1shot  (tmr_1shot)
	);

	interrupter u_interrupter (
		.clk               (clk),
		.rst_n             (rst_n),
		.int0              (int0),
		.rx_1shot          (rx_1shot),
		.tmr_1shot         (tmr_1shot),
		.csr_meie          (csr_meie),
		.io_we             (io_we),
		.io_wadr           (io_wadr),
		.io_wdata          (io_wdata),
		.io_radr_en        (io_radr_en),
		.io_radr           (io_radr),
		.rdata_in          (tmr_rdata),
		.rdata             (io_rdata),
		.g_interrupt       (g_interrupt),
		.g_interrupt_1shot (g_interrupt_1shot)
	);

endmodule

`default_nettype wire

/* logic/interrupter.sv */
/*
 * Interrupter
 * int0 synchronizer, per-source enable and status registers,
 * level and single-cycle global interrupt toward the core
 */
`default_nettype none
`include "io_irq_cfg.svh"

module interrupter (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                int0,
	input  wire logic                rx_1shot,
	input  wire logic                tmr_1shot,
	input  wire logic                csr_meie,
	input  wire logic                io_we,
	input  wire io_irq_pkg::io_adr_t io_wadr,
	input  wire logic [31:0]         io_wdata,
	input  wire logic                io_radr_en,
	input  wire io_irq_pkg::io_adr_t io_radr,
	input  wire logic [31:0]         rdata_in,
	output logic [31:0]              rdata,
	output logic                     g_interrupt,
	output logic                     g_interrupt_1shot
);

	localparam int N = `IRQ_SRC_NUM;

	logic [2:0]   int0_sync;
	logic         int0_1shot;
	logic [N-1:0] src_pulse;
	logic [N-1:0] int_enable;
	logic [N-1:0] int_status;
	logic [N-1:0] status_set;
	logic [N-1:0] status_clr;
	logic         we_enable;
	logic         we_status;
	logic         re_enable;
	logic         re_status;
	logic         re_enable_dly;
	logic         re_status_dly;
	logic         g_interrupt_dly;

	// two flops against metastability, third for the edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			int0_sync <= 3'b000;
		else
			int0_sync <= {int0_sync[1:0], int0};
	end

	assign int0_1shot = int0_sync[1] & ~int0_sync[2];

	assign src_pulse[io_irq_pkg::IRQ_RX]   = rx_1shot;
	assign src_pulse[io_irq_pkg::IRQ_INT0] = int0_1shot;
	assign src_pulse[io_irq_pkg::IRQ_TMR]  = tmr_1shot;

	assign we_enable = io_we & (io_wadr == `SYS_INT_ENABLE);
	assign we_status = io_we & (io_wadr == `SYS_INT_STATUS);
	assign re_enable = io_radr_en & (io_radr == `SYS_INT_ENABLE);
	assign re_status = io_radr_en & (io_radr == `SYS_INT_STATUS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			int_enable <= '0;
		else if (we_enable)
			int_enable <= io_wdata[N-1:0];
	end

	// write 0 clears a bit, write 1 keeps it
	assign status_clr = {N{we_status}} & ~io_wdata[N-1:0];
	assign status_set = {N{csr_meie}} & int_enable & src_pulse;

	// clear wins over a set in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			int_status <= '0;
		else
			int_status <= (int_status | status_set) & ~status_clr;
	end

	assign g_interrupt = |int_status;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			g_interrupt_dly <= 1'b0;
			re_enable_dly   <= 1'b0;
			re_status_dly   <= 1'b0;
		end else begin
			g_interrupt_dly <= g_interrupt;
			re_enable_dly   <= re_enable;
			re_status_dly   <= re_status;
		end
	end

	assign g_interrupt_1shot = g_interrupt & ~g_interrupt_dly;

	assign rdata = re_enable_dly ? {{(32 - N){1'b0}}, int_enable} :
	               re_status_dly ? {{(32 - N){1'b0}}, int_status} : rdata_in;

endmodule

`default_nettype wire

/* logic/io_timer.sv */
/*
 * I/O timer
 * free-running 32-bit counter with a compare register and
 * a one-cycle match pulse, all registers readable on the chain
 */
`default_nettype none
`include "io_irq_cfg.svh"

module io_timer (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                io_we,
	input  wire io_irq_pkg::io_adr_t io_wadr,
	input  wire logic [31:0]         io_wdata,
	input  wire logic                io_radr_en,
	input  wire io_irq_pkg::io_adr_t io_radr,
	input  wire logic [31:0]         rdata_in,
	output logic [31:0]              rdata,
	output logic                     tmr_1shot
);

	logic [31:0] tmr_ctrl;
	logic [31:0] tmr_count;
	logic [31:0] tmr_cmp;
	logic        tmr_en;
	logic        we_ctrl;
	logic        we_count;
	logic        we_cmp;
	logic [2:0]  re_sel;
	logic [2:0]  re_sel_dly;

	assign we_ctrl  = io_we & (io_wadr == `TMR_CTRL);
	assign we_count = io_we & (io_wadr == `TMR_COUNT);
	assign we_cmp   = io_we & (io_wadr == `TMR_CMP);

	// only bit 0 has a function, the rest is kept for readback
	assign tmr_en = tmr_ctrl[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tmr_ctrl <= 32'd0;
			tmr_cmp  <= 32'd0;
		end else begin
			if (we_ctrl)
				tmr_ctrl <= io_wdata;
			if (we_cmp)
				tmr_cmp <= io_wdata;
		end
	end

	// load has priority over counting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tmr_count <= 32'd0;
		else if (we_count)
			tmr_count <= io_wdata;
		else if (tmr_en)
			tmr_count <= tmr_count + 32'd1;
	end

	// count moves on next cycle, so one cycle only
	assign tmr_1shot = tmr_en & (tmr_count == tmr_cmp);

	// read select, one-hot
	assign re_sel[0] = io_radr_en & (io_radr == `TMR_CTRL);
	assign re_sel[1] = io_radr_en & (io_radr == `TMR_COUNT);
	assign re_sel[2] = io_radr_en & (io_radr == `TMR_CMP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			re_sel_dly <= 3'b000;
		else
			re_sel_dly <= re_sel;
	end

	assign rdata = re_sel_dly[0] ? tmr_ctrl  :
	               re_sel_dly[1] ? tmr_count :
	               re_sel_dly[2] ? tmr_cmp   : rdata_in;

endmodule

`default_nettype wire

/* logic/uart_rx_fsm.sv */
/*
 * UART receiver
 * samples rx mid-bit, assembles one byte LSB first and
 * reports it with valid and framing flags on the I/O read chain
 */
`default_nettype none
`include "io_irq_cfg.svh"

module uart_rx_fsm (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                rx,
	input  wire logic                io_radr_en,
	input  wire io_irq_pkg::io_adr_t io_radr,
	input  wire logic [31:0]         rdata_in,
	output logic [31:0]              rdata,
	output logic                     rx_1shot
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_CLKS_PER_BIT - 1);

	io_irq_pkg::uart_state_e state;
	logic [2:0]       rx_sync;
	logic [CNT_W-1:0] bit_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;
	logic [7:0]       rx_data;
	logic             rx_valid;
	logic             frame_err;
	logic             re_rxdata;
	logic             re_rxdata_dly;
	logic             rx_fall;
	logic             bit_done;

	// rx is asynchronous, extra stage for edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rx_sync <= 3'b000;
		else
			rx_sync <= {rx_sync[1:0], rx};
	end

	assign rx_fall  = rx_sync[2] & ~rx_sync[1];
	assign bit_done = (bit_cnt == FULL_BIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= io_irq_pkg::IDLE;
			bit_cnt  <= '0;
			bit_idx  <= 3'd0;
			rx_1shot <= 1'b0;
		end else begin
			rx_1shot <= 1'b0;
			case (state)
				io_irq_pkg::IDLE: begin
					bit_cnt <= '0;
					bit_idx <= 3'd0;
					if (rx_fall)
						state <= io_irq_pkg::START;
				end
				io_irq_pkg::START: begin
					// recheck the start bit at its middle
					if (bit_cnt == HALF_BIT) begin
						bit_cnt <= '0;
						state   <= rx_sync[1] ? io_irq_pkg::IDLE : io_irq_pkg::DATA;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
				io_irq_pkg::DATA: begin
					if (bit_done) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= io_irq_pkg::STOP;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
				io_irq_pkg::STOP: begin
					if (bit_done) begin
						bit_cnt  <= '0;
						rx_1shot <= rx_sync[1];
						state    <= io_irq_pkg::IDLE;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
				default: state <= io_irq_pkg::IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			shift_reg <= 8'd0;
		else if (state == io_irq_pkg::DATA && bit_done)
			shift_reg <= {rx_sync[1], shift_reg[7:1]};
	end

	assign re_rxdata = io_radr_en & (io_radr == `UART_RXDATA);

	// a new byte wins over a clearing read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_data       <= 8'd0;
			rx_valid      <= 1'b0;
			frame_err     <= 1'b0;
			re_rxdata_dly <= 1'b0;
		end else begin
			re_rxdata_dly <= re_rxdata;
			if (state == io_irq_pkg::STOP && bit_done) begin
				if (rx_sync[1]) begin
					rx_data  <= shift_reg;
					rx_valid <= 1'b1;
				end else begin
					frame_err <= 1'b1;
				end
			end else if (re_rxdata_dly) begin
				rx_valid  <= 1'b0;
				frame_err <= 1'b0;
			end
		end
	end

	assign rdata = re_rxdata_dly ? {22'd0, frame_err, rx_valid, rx_data} : rdata_in;

endmodule

`default_nettype wire

/* logic/io_irq_pkg.sv */
/*
 * I/O interrupt subsystem shared types
 * bus word address, interrupt source positions and UART receive states
 */
`default_nettype none

package io_irq_pkg;

	// word address of the I/O port, byte offset bits dropped
	typedef logic [15:2] io_adr_t;

	// bit position of each source in the enable and status words
	typedef enum logic [1:0] {
		IRQ_RX   = 2'd0,
		IRQ_INT0 = 2'd1,
		IRQ_TMR  = 2'd2
	} irq_src_e;

	// UART receive FSM
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		START = 2'd1,
		DATA  = 2'd2,
		STOP  = 2'd3
	} uart_state_e;

endpackage

`default_nettype wire

/* logic/io_irq_cfg.svh */
/*
 * I/O interrupt subsystem configuration
 * register map of the I/O port and UART bit timing
 */
`ifndef IO_IRQ_CFG_SVH
`define IO_IRQ_CFG_SVH

// number of interrupt sources, also width of enable and status
`define IRQ_SRC_NUM 3

// interrupter registers
`define SYS_INT_ENABLE 14'h3E80
`define SYS_INT_STATUS 14'h3E81

// UART receive data, flags in bits 9:8
`define UART_RXDATA 14'h3E90

// timer registers
`define TMR_CTRL  14'h3EA0
`define TMR_COUNT 14'h3EA1
`define TMR_CMP   14'h3EA2

// clocks per serial bit
`define UART_CLKS_PER_BIT 8

`endif
